// ==== commit_unit.sv ====
// Commit unit turning the head entry into a masked register file write
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
  input  rob_types_pkg::rob_entry_t head_entry,
  input  logic                      commit_ready,
  output logic                      commit_valid,
  output rob_types_pkg::commit_t    commit,
  output logic                      pop
);

  // First byte at or past the faulting element
  logic [6:0]                         cut_byte;
  logic [rob_cfg_pkg::VLEN_BYTES-1:0] keep_mask;

  // ============================================================
  // Exception cut-off
  // ============================================================

  always_comb begin
    case (head_entry.sew)
      rob_cfg_pkg::SEW32: cut_byte = {head_entry.exc_index, 2'b00};
      rob_cfg_pkg::SEW16: cut_byte = {1'b0, head_entry.exc_index, 1'b0};
      default:            cut_byte = {2'b00, head_entry.exc_index};
    endcase
  end

  // Cut-off past the last byte keeps the whole register
  assign keep_mask = ~({rob_cfg_pkg::VLEN_BYTES{1'b1}} << cut_byte);

  // ============================================================
  // Register file write
  // ============================================================

  assign commit_valid = head_entry.valid;

  always_comb begin
    commit.vd        = head_entry.vd;
    commit.data      = head_entry.data;
    commit.exception = head_entry.exception;
    if (head_entry.exception) begin
      commit.wen = head_entry.wen & keep_mask;
    end else begin
      commit.wen = head_entry.wen;
    end
  end

  assign pop = commit_valid & commit_ready;

endmodule

`default_nettype wire

// ==== completion_packer.sv ====
// Completion packer with lane result register and expansion to entry-wide data and byte enables
`timescale 1ns/1ps
`default_nettype none

module completion_packer #(
  parameter int NUM_ENTRY = 16
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    cpl_valid,
  input  rob_types_pkg::cpl_req_t cpl,
  input  logic                    flush,
  output logic                    wr_valid,
  output rob_types_pkg::entry_wr_t wr
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  rob_types_pkg::cpl_req_t       cpl_q;
  logic                          cpl_vld_q;
  rob_types_pkg::entry_wr_t      wr_d;
  rob_types_pkg::entry_wr_t      wr_q;
  logic                          wr_vld_q;
  logic [rob_cfg_pkg::VLEN-1:0]       pair_data;
  logic [rob_cfg_pkg::VLEN_BYTES-1:0] pair_wen;
  logic [3:0]                    byte_off;

  // ============================================================
  // Input stage
  // ============================================================

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cpl_vld_q <= 1'b0;
    end else begin
      cpl_vld_q <= cpl_valid & ~flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpl_valid) begin
      cpl_q <= cpl;
    end
  end

  // ============================================================
  // Expansion
  // ============================================================

  // Two elements side by side and moved to the slot's byte offset
  always_comb begin
    pair_data = '0;
    pair_wen  = '0;
    byte_off  = '0;
    case (cpl_q.sew)
      rob_cfg_pkg::SEW32: begin
        pair_data[63:0] = {cpl_q.wdata.w32.e1, cpl_q.wdata.w32.e0};
        pair_wen[7:0]   = {{4{cpl_q.elem_en[1]}}, {4{cpl_q.elem_en[0]}}};
        byte_off        = {cpl_q.slot[0], 3'b000};
      end
      rob_cfg_pkg::SEW16: begin
        pair_data[31:0] = {cpl_q.wdata.w16.e1, cpl_q.wdata.w16.e0};
        pair_wen[3:0]   = {{2{cpl_q.elem_en[1]}}, {2{cpl_q.elem_en[0]}}};
        byte_off        = {cpl_q.slot[1:0], 2'b00};
      end
      default: begin
        pair_data[15:0] = {cpl_q.wdata.w8.e1, cpl_q.wdata.w8.e0};
        pair_wen[1:0]   = cpl_q.elem_en;
        byte_off        = {cpl_q.slot, 1'b0};
      end
    endcase
  end

  always_comb begin
    wr_d                  = '0;
    wr_d.index[IDX_W-1:0] = cpl_q.index[IDX_W-1:0];
    wr_d.data             = pair_data << {byte_off, 3'b000};
    wr_d.wen              = pair_wen << byte_off;
    wr_d.sew              = cpl_q.sew;
    wr_d.exception        = cpl_q.exception;
    wr_d.exc_index        = cpl_q.exc_index;
    wr_d.last             = cpl_q.last;
  end

  // ============================================================
  // Output stage
  // ============================================================

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_vld_q <= 1'b0;
    end else begin
      wr_vld_q <= cpl_vld_q & ~flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpl_vld_q) begin
      wr_q <= wr_d;
    end
  end

  assign wr_valid = wr_vld_q;
  assign wr       = wr_q;

endmodule

`default_nettype wire

// ==== rob_cfg_pkg.sv ====
// Vector length constants, element width and register grouping encodings
`default_nettype none

package rob_cfg_pkg;

  // ============================================================
  // Vector geometry
  // ============================================================

  // One entry holds a full vector register
  localparam int unsigned VLEN       = 128;
  localparam int unsigned VLEN_BYTES = VLEN / 8;

  // A lane result carries two elements
  localparam int unsigned LANE_WIDTH = 64;

  // Vector register number width
  localparam int unsigned VREG_ADDR_W = 5;

  // Slot number inside an entry of up to eight slots at SEW8
  localparam int unsigned SLOT_W = 3;

  // ============================================================
  // Encodings
  // ============================================================

  // Element width of a result
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // Register grouping with fractional groupings folded into LMUL1
  typedef enum logic [2:0] {
    LMUL1 = 3'd0,
    LMUL2 = 3'd1,
    LMUL4 = 3'd2,
    LMUL8 = 3'd3
  } lmul_t;

endpackage

`default_nettype wire

// ==== rob_storage.sv ====
// Entry array with wrap-bit head and tail pointers, allocation, merge writes and pop
`timescale 1ns/1ps
`default_nettype none

module rob_storage #(
  parameter int NUM_ENTRY = 16
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      alloc_valid,
  input  rob_types_pkg::alloc_req_t alloc,
  output logic                      alloc_ready,
  output logic [4:0]                alloc_index,
  input  logic                      wr_valid,
  input  rob_types_pkg::entry_wr_t  wr,
  input  logic                      pop,
  input  logic                      flush,
  output rob_types_pkg::rob_entry_t head_entry
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  rob_types_pkg::rob_entry_t rob      [NUM_ENTRY];
  rob_types_pkg::rob_entry_t next_rob [NUM_ENTRY];

  // Extra top bit tells full from empty
  logic [IDX_W:0]   head;
  logic [IDX_W:0]   tail;
  logic [IDX_W:0]   next_head;
  logic [IDX_W:0]   next_tail;
  logic [IDX_W:0]   free_cnt;
  logic [IDX_W:0]   alloc_num;
  logic [IDX_W-1:0] head_sel;
  logic [IDX_W-1:0] tail_sel;
  logic [IDX_W-1:0] wr_sel;
  logic             alloc_fire;

  assign head_sel = head[IDX_W-1:0];
  assign tail_sel = tail[IDX_W-1:0];
  assign wr_sel   = wr.index[IDX_W-1:0];

  // ============================================================
  // Allocation
  // ============================================================

  always_comb begin
    case (alloc.lmul)
      rob_cfg_pkg::LMUL2: alloc_num = (IDX_W+1)'(2);
      rob_cfg_pkg::LMUL4: alloc_num = (IDX_W+1)'(4);
      rob_cfg_pkg::LMUL8: alloc_num = (IDX_W+1)'(8);
      default:            alloc_num = (IDX_W+1)'(1);
    endcase
  end

  assign free_cnt    = (IDX_W+1)'(NUM_ENTRY) - (tail - head);
  assign alloc_ready = free_cnt >= alloc_num;
  assign alloc_fire  = alloc_valid & alloc_ready;

  always_comb begin
    alloc_index              = '0;
    alloc_index[IDX_W-1:0]   = tail_sel;
  end

  // ============================================================
  // Pointers
  // ============================================================

  always_comb begin
    next_head = head;
    next_tail = tail;
    if (pop) begin
      next_head = head + 1'b1;
    end
    if (alloc_fire) begin
      next_tail = tail + alloc_num;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

  // ============================================================
  // Entry updates
  // ============================================================

  always_comb begin
    next_rob = rob;

    // Committed entry goes back to empty
    if (pop) begin
      next_rob[head_sel] = '0;
    end

    // Base register in the first entry of a group and base+k after it
    for (int k = 0; k < 8; k++) begin
      if (alloc_fire && k < int'(alloc_num)) begin
        next_rob[tail_sel + IDX_W'(k)].vd = alloc.vd + (rob_cfg_pkg::VREG_ADDR_W)'(k);
      end
    end

    if (wr_valid) begin
      for (int b = 0; b < rob_cfg_pkg::VLEN_BYTES; b++) begin
        if (wr.wen[b]) begin
          next_rob[wr_sel].data[b*8 +: 8] = wr.data[b*8 +: 8];
        end
      end
      next_rob[wr_sel].wen = rob[wr_sel].wen | wr.wen;
      next_rob[wr_sel].sew = wr.sew;
      // Only the first exception of an entry is kept
      if (wr.exception && !rob[wr_sel].exception) begin
        next_rob[wr_sel].exception = 1'b1;
        next_rob[wr_sel].exc_index = wr.exc_index;
      end
      if (wr.last) begin
        next_rob[wr_sel].valid = 1'b1;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        rob[i] <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        rob[i] <= '0;
      end
    end else begin
      rob <= next_rob;
    end
  end

  assign head_entry = rob[head_sel];

endmodule

`default_nettype wire

// ==== rob_types_pkg.sv ====
// Request, entry and commit structs plus the lane word union
`default_nettype none

package rob_types_pkg;

  // Index fields fit the largest buffer of 16 entries
  localparam int unsigned ROB_IDX_W = 5;

  // One 64-bit lane word read three ways by element width
  typedef union packed {
    struct packed {
      logic [31:0] e1;
      logic [31:0] e0;
    } w32;
    struct packed {
      logic [15:0] pad1;
      logic [15:0] e1;
      logic [15:0] pad0;
      logic [15:0] e0;
    } w16;
    struct packed {
      logic [23:0] pad1;
      logic [7:0]  e1;
      logic [23:0] pad0;
      logic [7:0]  e0;
    } w8;
  } lane_word_u;

  // Allocation at the tail
  typedef struct packed {
    rob_cfg_pkg::lmul_t                          lmul;
    logic [rob_cfg_pkg::VREG_ADDR_W-1:0]         vd;
  } alloc_req_t;

  // Lane result from a functional unit
  typedef struct packed {
    logic [ROB_IDX_W-1:0]                        index;
    logic [rob_cfg_pkg::SLOT_W-1:0]              slot;
    rob_cfg_pkg::sew_t                           sew;
    lane_word_u                                  wdata;
    logic [1:0]                                  elem_en;
    logic                                        exception;
    logic [4:0]                                  exc_index;
    logic                                        last;
  } cpl_req_t;

  // Packed write into one entry
  typedef struct packed {
    logic [ROB_IDX_W-1:0]                        index;
    logic [rob_cfg_pkg::VLEN-1:0]                data;
    logic [rob_cfg_pkg::VLEN_BYTES-1:0]          wen;
    rob_cfg_pkg::sew_t                           sew;
    logic                                        exception;
    logic [4:0]                                  exc_index;
    logic                                        last;
  } entry_wr_t;

  // Stored entry
  typedef struct packed {
    logic [rob_cfg_pkg::VLEN-1:0]                data;
    logic [rob_cfg_pkg::VLEN_BYTES-1:0]          wen;
    logic [rob_cfg_pkg::VREG_ADDR_W-1:0]         vd;
    rob_cfg_pkg::sew_t                           sew;
    logic                                        valid;
    logic                                        exception;
    logic [4:0]                                  exc_index;
  } rob_entry_t;

  // Write to the vector register file
  typedef struct packed {
    logic [rob_cfg_pkg::VREG_ADDR_W-1:0]         vd;
    logic [rob_cfg_pkg::VLEN-1:0]                data;
    logic [rob_cfg_pkg::VLEN_BYTES-1:0]          wen;
    logic                                        exception;
  } commit_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_vector_rob \
  -o sim_vector_rob > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_vector_rob > sim.log 2>&1

grep -qx "=== PASS ===" sim.log \
  && { echo "Simulation passed, see sim.log"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb.f ====
rob_cfg_pkg.sv
rob_types_pkg.sv
completion_packer.sv
rob_storage.sv
commit_unit.sv
vector_rob.sv
vector_rob_checker.sv
tb_clock_gen.sv
tb_vector_rob.sv

// ==== tb_clock_gen.sv ====
// Testbench clock generator with power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release away from the rising edge
  initial begin
    nRST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_vector_rob.sv ====
// Testbench top with clock, DUT, checker bind, reference model and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_vector_rob;

  localparam int NUM_ENTRY = 16;
  localparam int WAIT_MAX  = 50;

  logic                      CLK;
  logic                      nRST;
  logic                      alloc_valid;
  rob_types_pkg::alloc_req_t alloc;
  logic                      alloc_ready;
  logic [4:0]                alloc_index;
  logic                      cpl_valid;
  rob_types_pkg::cpl_req_t   cpl;
  logic                      flush;
  logic                      commit_valid;
  rob_types_pkg::commit_t    commit;
  logic                      commit_ready;

  int errors;
  int tests;

  // Reference entry
  logic [127:0] m_data;
  logic [15:0]  m_wen;

  tb_clock_gen #(
    .PERIOD     (40),
    .RST_CYCLES (10)
  ) clk0 (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vector_rob #(
    .NUM_ENTRY (NUM_ENTRY)
  ) dut0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc_valid  (alloc_valid),
    .alloc        (alloc),
    .alloc_ready  (alloc_ready),
    .alloc_index  (alloc_index),
    .cpl_valid    (cpl_valid),
    .cpl          (cpl),
    .flush        (flush),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
  );

  bind vector_rob vector_rob_checker chk0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .alloc_valid  (alloc_valid),
    .alloc_ready  (alloc_ready),
    .alloc_index  (alloc_index),
    .flush        (flush),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
  );

  // ============================================================
  // Reference model
  // ============================================================

  function automatic int elem_bytes(input rob_cfg_pkg::sew_t sew);
    case (sew)
      rob_cfg_pkg::SEW32: return 4;
      rob_cfg_pkg::SEW16: return 2;
      default:            return 1;
    endcase
  endfunction

  // Element e sits at bit 32*e of the lane word and its bytes land at slot*2*esz + e*esz
  task automatic model_place(input rob_cfg_pkg::sew_t sew, input int slot,
                             input logic [63:0] word, input logic [1:0] en);
    int esz;
    int pos;
    esz = elem_bytes(sew);
    for (int e = 0; e < 2; e++) begin
      for (int j = 0; j < esz; j++) begin
        pos = slot * 2 * esz + e * esz + j;
        if (en[e]) begin
          m_data[pos*8 +: 8] = word[e*32 + j*8 +: 8];
          m_wen[pos]         = 1'b1;
        end
      end
    end
  endtask

  // Bytes below the faulting element survive
  function automatic logic [15:0] keep_below(input rob_cfg_pkg::sew_t sew, input int exc_idx);
    logic [15:0] keep;
    for (int b = 0; b < 16; b++) begin
      keep[b] = (b < exc_idx * elem_bytes(sew));
    end
    return keep;
  endfunction

  function automatic logic [63:0] random_lane_word();
    return {$urandom, $urandom};
  endfunction

  // ============================================================
  // Reporting
  // ============================================================

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: %s did not arrive within %0d cycles", what, WAIT_MAX);
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: %0d failed checks", tests, name, errors - start);
    end
  endtask

  task automatic check_commit(input rob_types_pkg::commit_t c, input logic [4:0] vd,
                              input logic [127:0] data, input logic [15:0] wen,
                              input logic exc, input string what);
    if (c.vd !== vd) begin
      report_fail($sformatf("%s: vd %0d, expected %0d", what, c.vd, vd));
    end
    if (c.data !== data) begin
      report_fail($sformatf("%s: data %h, expected %h", what, c.data, data));
    end
    if (c.wen !== wen) begin
      report_fail($sformatf("%s: wen %h, expected %h", what, c.wen, wen));
    end
    if (c.exception !== exc) begin
      report_fail($sformatf("%s: exception %b, expected %b", what, c.exception, exc));
    end
  endtask

  // ============================================================
  // Bus drivers
  // ============================================================

  // Called right after a falling edge with alloc_valid already high
  task automatic hold_alloc(output logic [4:0] idx);
    int n;
    n = 0;
    #1;
    while (!alloc_ready && n < WAIT_MAX) begin
      @(negedge CLK);
      #1;
      n++;
    end
    idx = alloc_index;
    if (!alloc_ready) begin
      report_timeout("alloc_ready");
    end
    @(negedge CLK);
    alloc_valid = 1'b0;
  endtask

  task automatic request_alloc(input rob_cfg_pkg::lmul_t lmul, input logic [4:0] vd,
                               output logic [4:0] idx);
    @(negedge CLK);
    alloc_valid = 1'b1;
    alloc.lmul  = lmul;
    alloc.vd    = vd;
    hold_alloc(idx);
  endtask

  // Drives one completion and records it in the model
  task automatic send_cpl(input logic [4:0] index, input int slot, input rob_cfg_pkg::sew_t sew,
                          input logic [63:0] word, input logic [1:0] en,
                          input logic exc, input int exc_idx, input logic last);
    @(negedge CLK);
    cpl_valid     = 1'b1;
    cpl.index     = index;
    cpl.slot      = 3'(slot);
    cpl.sew       = sew;
    cpl.wdata     = word;
    cpl.elem_en   = en;
    cpl.exception = exc;
    cpl.exc_index = 5'(exc_idx);
    cpl.last      = last;
    model_place(sew, slot, word, en);
    @(negedge CLK);
    cpl_valid = 1'b0;
  endtask

  task automatic wait_commit_valid();
    int n;
    n = 0;
    @(negedge CLK);
    while (!commit_valid && n < WAIT_MAX) begin
      @(negedge CLK);
      n++;
    end
    if (!commit_valid) begin
      report_timeout("commit_valid");
    end
  endtask

  task automatic take_commit(output rob_types_pkg::commit_t c);
    wait_commit_valid();
    c            = commit;
    commit_ready = 1'b1;
    @(negedge CLK);
    commit_ready = 1'b0;
  endtask

  task automatic flush_all();
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush  = 1'b0;
    m_data = '0;
    m_wen  = '0;
  endtask

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic test_alloc_full();
    int start;
    logic [4:0] idx;
    rob_types_pkg::commit_t c;
    start = errors;
    request_alloc(rob_cfg_pkg::LMUL8, 5'd16, idx);
    if (idx !== 5'd0) begin
      report_fail($sformatf("LMUL8 alloc_index %0d, expected 0", idx));
    end
    request_alloc(rob_cfg_pkg::LMUL4, 5'd0, idx);
    if (idx !== 5'd8) begin
      report_fail($sformatf("first LMUL4 alloc_index %0d, expected 8", idx));
    end
    request_alloc(rob_cfg_pkg::LMUL4, 5'd4, idx);
    if (idx !== 5'd12) begin
      report_fail($sformatf("second LMUL4 alloc_index %0d, expected 12", idx));
    end
    // Buffer full so a single entry request has to wait
    @(negedge CLK);
    alloc_valid = 1'b1;
    alloc.lmul  = rob_cfg_pkg::LMUL1;
    alloc.vd    = 5'd24;
    for (int i = 0; i < 4; i++) begin
      #1;
      if (alloc_ready) begin
        report_fail("alloc_ready high while the buffer is full");
      end
      @(negedge CLK);
    end
    m_data = '0;
    m_wen  = '0;
    send_cpl(5'd0, 0, rob_cfg_pkg::SEW32, random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
    take_commit(c);
    check_commit(c, 5'd16, m_data, m_wen, 1'b0, "head of LMUL8 group");
    hold_alloc(idx);
    if (idx !== 5'd0) begin
      report_fail($sformatf("alloc after commit returned %0d, expected 0", idx));
    end
    // Second entry of the group carries base+1
    m_data = '0;
    m_wen  = '0;
    send_cpl(5'd1, 0, rob_cfg_pkg::SEW32, random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
    take_commit(c);
    check_commit(c, 5'd17, m_data, m_wen, 1'b0, "second entry of LMUL8 group");
    flush_all();
    finish_test("allocation and full", start);
  endtask

  task automatic test_sew32();
    int start;
    logic [4:0] idx;
    rob_types_pkg::commit_t c;
    start = errors;
    request_alloc(rob_cfg_pkg::LMUL1, 5'd7, idx);
    send_cpl(idx, 0, rob_cfg_pkg::SEW32, random_lane_word(), 2'b11, 1'b0, 0, 1'b0);
    send_cpl(idx, 1, rob_cfg_pkg::SEW32, random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
    take_commit(c);
    check_commit(c, 5'd7, m_data, 16'hFFFF, 1'b0, "SEW32 two slots");
    finish_test("SEW32 packing", start);
  endtask

  task automatic test_sew16_sew8();
    int start;
    logic [4:0] idx0;
    logic [4:0] idx1;
    rob_types_pkg::commit_t c;
    start = errors;
    request_alloc(rob_cfg_pkg::LMUL1, 5'd3, idx0);
    request_alloc(rob_cfg_pkg::LMUL1, 5'd4, idx1);
    m_data = '0;
    m_wen  = '0;
    send_cpl(idx0, 0, rob_cfg_pkg::SEW16, random_lane_word(), 2'b11, 1'b0, 0, 1'b0);
    send_cpl(idx0, 2, rob_cfg_pkg::SEW16, random_lane_word(), 2'b01, 1'b0, 0, 1'b1);
    take_commit(c);
    check_commit(c, 5'd3, m_data, m_wen, 1'b0, "SEW16 slots 0 and 2");
    m_data = '0;
    m_wen  = '0;
    send_cpl(idx1, 1, rob_cfg_pkg::SEW8, random_lane_word(), 2'b10, 1'b0, 0, 1'b0);
    send_cpl(idx1, 5, rob_cfg_pkg::SEW8, random_lane_word(), 2'b11, 1'b0, 0, 1'b0);
    send_cpl(idx1, 7, rob_cfg_pkg::SEW8, random_lane_word(), 2'b01, 1'b0, 0, 1'b1);
    take_commit(c);
    check_commit(c, 5'd4, m_data, m_wen, 1'b0, "SEW8 slots 1, 5 and 7");
    finish_test("SEW16 and SEW8 packing", start);
  endtask

  task automatic test_out_of_order();
    int start;
    int order [3];
    logic [4:0] base;
    logic [4:0] idx;
    logic [127:0] exp_d [3];
    logic [15:0] exp_w [3];
    rob_types_pkg::commit_t held;
    rob_types_pkg::commit_t c;
    start = errors;
    order = '{2, 0, 1};
    request_alloc(rob_cfg_pkg::LMUL1, 5'd10, base);
    request_alloc(rob_cfg_pkg::LMUL1, 5'd11, idx);
    request_alloc(rob_cfg_pkg::LMUL1, 5'd12, idx);
    foreach (order[i]) begin
      m_data = '0;
      m_wen  = '0;
      send_cpl(5'((int'(base) + order[i]) % NUM_ENTRY), 0, rob_cfg_pkg::SEW32,
               random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
      exp_d[order[i]] = m_data;
      exp_w[order[i]] = m_wen;
    end
    // Stall the oldest commit for a few cycles
    wait_commit_valid();
    held = commit;
    for (int i = 0; i < 4; i++) begin
      @(negedge CLK);
      if (!commit_valid || commit !== held) begin
        report_fail("commit changed while commit_ready was low");
      end
    end
    for (int i = 0; i < 3; i++) begin
      take_commit(c);
      check_commit(c, 5'(10 + i), exp_d[i], exp_w[i], 1'b0,
                   $sformatf("in-order commit %0d", i));
    end
    finish_test("out-of-order completion", start);
  endtask

  task automatic test_exception();
    int start;
    logic [4:0] idx;
    rob_types_pkg::commit_t c;
    start = errors;
    request_alloc(rob_cfg_pkg::LMUL1, 5'd20, idx);
    m_data = '0;
    m_wen  = '0;
    for (int s = 0; s < 4; s++) begin
      send_cpl(idx, s, rob_cfg_pkg::SEW16, random_lane_word(), 2'b11, s == 1, 3, s == 3);
    end
    take_commit(c);
    check_commit(c, 5'd20, m_data, m_wen & keep_below(rob_cfg_pkg::SEW16, 3), 1'b1,
                 "SEW16 exception at element 3");
    request_alloc(rob_cfg_pkg::LMUL1, 5'd21, idx);
    m_data = '0;
    m_wen  = '0;
    for (int s = 0; s < 8; s++) begin
      send_cpl(idx, s, rob_cfg_pkg::SEW8, random_lane_word(), 2'b11, s == 2, 5, s == 7);
    end
    take_commit(c);
    check_commit(c, 5'd21, m_data, m_wen & keep_below(rob_cfg_pkg::SEW8, 5), 1'b1,
                 "SEW8 exception at element 5");
    finish_test("exception masking", start);
  endtask

  task automatic test_flush();
    int start;
    logic [4:0] base;
    logic [4:0] idx;
    start = errors;
    request_alloc(rob_cfg_pkg::LMUL2, 5'd0, base);
    request_alloc(rob_cfg_pkg::LMUL1, 5'd2, idx);
    send_cpl(base, 0, rob_cfg_pkg::SEW32, random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
    send_cpl(5'((int'(base) + 1) % NUM_ENTRY), 0, rob_cfg_pkg::SEW32,
             random_lane_word(), 2'b11, 1'b0, 0, 1'b1);
    wait_commit_valid();
    // Last completion is still in the packer when the flush hits
    cpl.index   = idx;
    cpl.last    = 1'b1;
    cpl_valid   = 1'b1;
    @(negedge CLK);
    cpl_valid = 1'b0;
    flush_all();
    alloc.lmul = rob_cfg_pkg::LMUL1;
    for (int i = 0; i < 6; i++) begin
      #1;
      if (commit_valid) begin
        report_fail("commit_valid high after flush");
      end
      if (!alloc_ready) begin
        report_fail("alloc_ready low after flush");
      end
      @(negedge CLK);
    end
    request_alloc(rob_cfg_pkg::LMUL1, 5'd9, idx);
    if (idx !== 5'd0) begin
      report_fail($sformatf("alloc after flush returned %0d, expected 0", idx));
    end
    flush_all();
    finish_test("flush", start);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    int n;
    void'($urandom(14723));
    alloc_valid  = 1'b0;
    alloc        = '0;
    cpl_valid    = 1'b0;
    cpl          = '0;
    flush        = 1'b0;
    commit_ready = 1'b0;
    errors       = 0;
    tests        = 0;
    m_data       = '0;
    m_wen        = '0;
    n            = 0;
    while (nRST !== 1'b1 && n < WAIT_MAX) begin
      @(negedge CLK);
      n++;
    end
    if (nRST !== 1'b1) begin
      report_timeout("reset release");
    end
    test_alloc_full();
    test_sew32();
    test_sew16_sew8();
    test_out_of_order();
    test_exception();
    test_flush();
    repeat (2) @(negedge CLK);
    errors += dut0.chk0.fail_cnt;
    $display("Tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vector_rob.sv ====
// Vector reorder buffer top level with completion packer, entry storage and commit unit
`timescale 1ns/1ps
`default_nettype none

module vector_rob #(
  parameter int NUM_ENTRY = 16
) (
  input  logic                      CLK,
  input  logic                      nRST,

  // Allocation
  input  logic                      alloc_valid,
  input  rob_types_pkg::alloc_req_t alloc,
  output logic                      alloc_ready,
  output logic [4:0]                alloc_index,

  // Completion, shared by all functional units
  input  logic                      cpl_valid,
  input  rob_types_pkg::cpl_req_t   cpl,

  input  logic                      flush,

  // Commit
  output logic                      commit_valid,
  output rob_types_pkg::commit_t    commit,
  input  logic                      commit_ready
);

  logic                      wr_valid;
  rob_types_pkg::entry_wr_t  wr;
  rob_types_pkg::rob_entry_t head_entry;
  logic                      pop;

  completion_packer #(
    .NUM_ENTRY (NUM_ENTRY)
  ) packer0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .flush     (flush),
    .wr_valid  (wr_valid),
    .wr        (wr)
  );

  rob_storage #(
    .NUM_ENTRY (NUM_ENTRY)
  ) storage0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .alloc_valid (alloc_valid),
    .alloc       (alloc),
    .alloc_ready (alloc_ready),
    .alloc_index (alloc_index),
    .wr_valid    (wr_valid),
    .wr          (wr),
    .pop         (pop),
    .flush       (flush),
    .head_entry  (head_entry)
  );

  commit_unit commit0 (
    .head_entry   (head_entry),
    .commit_ready (commit_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .pop          (pop)
  );

endmodule

`default_nettype wire

// ==== vector_rob_checker.sv ====
// Concurrent assertions on the allocation, commit and flush behavior of the ROB
`timescale 1ns/1ps
`default_nettype none

module vector_rob_checker (
  input logic                   CLK,
  input logic                   nRST,
  input logic                   alloc_valid,
  input logic                   alloc_ready,
  input logic [4:0]             alloc_index,
  input logic                   flush,
  input logic                   commit_valid,
  input rob_types_pkg::commit_t commit,
  input logic                   commit_ready
);

  int fail_cnt = 0;

  // Stalled commit keeps its payload
  commit_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (commit_valid && !commit_ready && !flush) |=> $stable(commit))
    else begin
      fail_cnt++;
      $error("commit changed while commit_ready was low");
    end

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !commit_valid)
    else begin
      fail_cnt++;
      $error("commit_valid high on the cycle after a flush");
    end

  ready_after_reset: assert property (@(posedge CLK)
    $rose(nRST) |-> alloc_ready)
    else begin
      fail_cnt++;
      $error("alloc_ready low after reset");
    end

  // Tail only moves on an accepted allocation
  no_alloc_when_busy: assert property (@(posedge CLK) disable iff (!nRST)
    (alloc_valid && !alloc_ready && !flush) |=> $stable(alloc_index))
    else begin
      fail_cnt++;
      $error("allocation accepted while alloc_ready was low");
    end

endmodule

`default_nettype wire
